// File: rv32_exec_pipe.f
+incdir+src
src/rv32_exec_pkg.sv
src/alu.sv
src/reg_file.sv
src/operand_fetch.sv
src/execute_stage.sv
src/writeback_stage.sv
src/rv32_exec_pipe.sv
verif/rv32_exec_pipe_tb.sv

// File: Bender.yml
package:
  name: rv32_exec_pipe

export_include_dirs:
  - src

sources:
  - files:
      - src/rv32_exec_pkg.sv
      - src/alu.sv
      - src/reg_file.sv
      - src/operand_fetch.sv
      - src/execute_stage.sv
      - src/writeback_stage.sv
      - src/rv32_exec_pipe.sv
  - target: test
    files:
      - verif/rv32_exec_pipe_tb.sv

// File: verif/rv32_exec_pipe_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_pipe_tb import rv32_exec_pkg::*; ();

  localparam int NUM_SLOTS = 2000;

  logic      clk_i = 1'b0;
  logic      reset_i = 1'b1;
  logic      issue_valid_i = 1'b0;
  alu_op_e   issue_op_i = ALU_ADD;
  reg_addr_t issue_rd_i = '0;
  reg_addr_t issue_rs1_i = '0;
  reg_addr_t issue_rs2_i = '0;
  word_t     issue_imm_i = '0;
  logic      issue_use_imm_i = 1'b0;
  logic      issue_branch_i = 1'b0;
  br_cond_e  issue_cond_i = BR_EQ;
  word_t     issue_pc_i = '0;
  logic      wb_valid_o;
  reg_addr_t wb_rd_o;
  word_t     wb_data_o;
  logic      branch_taken_o;
  word_t     branch_target_o;

  integer    seed = 32'h663ba261;
  int        mismatches = 0;
  int        timeouts = 0;
  int        pending = 0;
  int        squash_left = 0;
  word_t     model_regs [32];
  br_cond_e  cond_table [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};

  // one expected entry per issue slot
  logic      exp_wbv_q [$];
  reg_addr_t exp_rd_q [$];
  word_t     exp_data_q [$];
  logic      exp_br_q [$];
  word_t     exp_tgt_q [$];

  always #2 clk_i = ~clk_i;

  rv32_exec_pipe i_rv32_exec_pipe (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .issue_valid_i   (issue_valid_i),
    .issue_op_i      (issue_op_i),
    .issue_rd_i      (issue_rd_i),
    .issue_rs1_i     (issue_rs1_i),
    .issue_rs2_i     (issue_rs2_i),
    .issue_imm_i     (issue_imm_i),
    .issue_use_imm_i (issue_use_imm_i),
    .issue_branch_i  (issue_branch_i),
    .issue_cond_i    (issue_cond_i),
    .issue_pc_i      (issue_pc_i),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic signed_less(input word_t a, input word_t b);
    if (a[31] != b[31]) begin
      return a[31];
    end
    return a < b;
  endfunction

  function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    logic [63:0] ext;
    int          sh;
    sh = b[4:0];
    ext = {{32{a[31]}}, a} >> sh;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_SLL:  return a << sh;
      ALU_SLT:  return {31'd0, signed_less(a, b)};
      ALU_SLTU: return {31'd0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return ext[31:0];
      ALU_OR:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic logic cond_holds(input br_cond_e cond, input word_t a, input word_t b);
    case (cond)
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return signed_less(a, b);
      BR_GE:   return !signed_less(a, b);
      BR_LTU:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input word_t got, input word_t exp);
    mismatches++;
    $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
  endtask

  task automatic push_expected(input logic wbv, input reg_addr_t rd, input word_t data,
                               input logic br, input word_t tgt);
    exp_wbv_q.push_back(wbv);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_br_q.push_back(br);
    exp_tgt_q.push_back(tgt);
    if (wbv || br) begin
      pending++;
    end
  endtask

  // outputs after edge k belong to the slot issued at edge k-2
  task automatic check_outputs();
    logic      e_wbv;
    reg_addr_t e_rd;
    word_t     e_data;
    logic      e_br;
    word_t     e_tgt;
    e_wbv = exp_wbv_q.pop_front();
    e_rd = exp_rd_q.pop_front();
    e_data = exp_data_q.pop_front();
    e_br = exp_br_q.pop_front();
    e_tgt = exp_tgt_q.pop_front();
    // an expected event counts as seen only when the DUT shows it
    if ((e_wbv && wb_valid_o === 1'b1) || (e_br && branch_taken_o === 1'b1)) begin
      pending--;
    end
    assert (wb_valid_o === e_wbv) else report_mismatch("wb_valid_o", wb_valid_o, e_wbv);
    if (e_wbv) begin
      assert (wb_rd_o === e_rd) else report_mismatch("wb_rd_o", wb_rd_o, e_rd);
      assert (wb_data_o === e_data) else report_mismatch("wb_data_o", wb_data_o, e_data);
    end
    assert (branch_taken_o === e_br) else report_mismatch("branch_taken_o", branch_taken_o, e_br);
    if (e_br) begin
      assert (branch_target_o === e_tgt) else begin
        report_mismatch("branch_target_o", branch_target_o, e_tgt);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // issue slots driven on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic run_slot(input logic active);
    logic        go;
    logic        squashed;
    logic [31:0] pick;
    alu_op_e     op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       imm;
    word_t       pc;
    logic        use_imm;
    logic        br;
    br_cond_e    cond;
    logic        e_wbv;
    logic        e_br;
    word_t       e_data;
    word_t       b_val;
    go = active && (($random(seed) & 3) != 0);
    pick = $unsigned($random(seed)) % 10;
    op = alu_op_e'(pick[3:0]);
    // small register range keeps dependencies dense
    rd = reg_addr_t'($random(seed) & 7);
    rs1 = reg_addr_t'($random(seed) & 7);
    rs2 = reg_addr_t'($random(seed) & 7);
    imm = (($random(seed) & 3) == 0) ? $random(seed) : ($random(seed) & 32'h1f);
    pc = $random(seed) & 32'hffff_fffc;
    use_imm = $random(seed) & 1;
    br = (($random(seed) & 7) == 0);
    pick = $unsigned($random(seed)) % 6;
    cond = cond_table[pick];
    e_wbv = 1'b0;
    e_br = 1'b0;
    e_data = '0;
    squashed = (squash_left != 0);
    if (squash_left != 0) begin
      squash_left--;
    end
    if (go && !squashed) begin
      b_val = use_imm ? imm : model_regs[rs2];
      if (br) begin
        if (cond_holds(cond, model_regs[rs1], model_regs[rs2])) begin
          e_br = 1'b1;
          squash_left = 3;
        end
      end else if (rd != '0) begin
        e_wbv = 1'b1;
        e_data = alu_model(op, model_regs[rs1], b_val);
        model_regs[rd] = e_data;
      end
    end
    push_expected(e_wbv, rd, e_data, e_br, pc + imm);
    issue_valid_i = go;
    issue_op_i = op;
    issue_rd_i = rd;
    issue_rs1_i = rs1;
    issue_rs2_i = rs2;
    issue_imm_i = imm;
    issue_use_imm_i = use_imm;
    issue_branch_i = br;
    issue_cond_i = cond;
    issue_pc_i = pc;
    @(posedge clk_i);
    @(negedge clk_i);
    check_outputs();
  endtask

  initial begin
    int wait_cycles;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // pipeline must come out of reset quiet
    assert (wb_valid_o === 1'b0) else report_mismatch("wb_valid_o", wb_valid_o, '0);
    assert (branch_taken_o === 1'b0) else report_mismatch("branch_taken_o", branch_taken_o, '0);
    push_expected(1'b0, '0, '0, 1'b0, '0);
    push_expected(1'b0, '0, '0, 1'b0, '0);
    for (int s = 0; s < NUM_SLOTS; s++) begin
      run_slot(1'b1);
    end
    // drain the last two slots, then wait for any result still owed
    wait_cycles = 0;
    while ((wait_cycles < 2 || pending != 0) && wait_cycles < 10) begin
      run_slot(1'b0);
      wait_cycles++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("timeout: %0d expected results never appeared", pending);
    end
    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/rv32_exec_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module rv32_exec_pipe import rv32_exec_pkg::*; (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic issue_valid_i,
  input  alu_op_e   issue_op_i,
  input  reg_addr_t issue_rd_i,
  input  reg_addr_t issue_rs1_i,
  input  reg_addr_t issue_rs2_i,
  input  word_t     issue_imm_i,
  input  wire logic issue_use_imm_i,
  input  wire logic issue_branch_i,
  input  br_cond_e  issue_cond_i,
  input  word_t     issue_pc_i,
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o,
  output logic      branch_taken_o,
  output word_t     branch_target_o
);

  // stage 3 outputs
  logic      of_valid;
  alu_op_e   of_op;
  reg_addr_t of_rd;
  reg_addr_t of_rs1;
  reg_addr_t of_rs2;
  word_t     of_imm;
  logic      of_use_imm;
  logic      of_branch;
  br_cond_e  of_cond;
  word_t     of_pc;
  word_t     rs1_data;
  word_t     rs2_data;

  // stage 4 outputs
  logic      ex_valid;
  reg_addr_t ex_rd;
  word_t     ex_result;
  logic      ex_branch;
  br_cond_e  ex_cond;
  logic      ex_equal;
  logic      ex_less;
  logic      ex_less_signed;
  word_t     ex_target;

  ////////////////////////////////////////////////////////////
  // register file, written from writeback
  ////////////////////////////////////////////////////////////

  reg_file i_reg_file (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (issue_rs1_i),
    .rs2_addr_i (issue_rs2_i),
    .wr_en_i    (wb_valid_o),
    .wr_addr_i  (wb_rd_o),
    .wr_data_i  (wb_data_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  ////////////////////////////////////////////////////////////
  // pipeline stages
  ////////////////////////////////////////////////////////////

  operand_fetch i_operand_fetch (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .flush_i         (branch_taken_o),
    .issue_valid_i   (issue_valid_i),
    .issue_op_i      (issue_op_i),
    .issue_rd_i      (issue_rd_i),
    .issue_rs1_i     (issue_rs1_i),
    .issue_rs2_i     (issue_rs2_i),
    .issue_imm_i     (issue_imm_i),
    .issue_use_imm_i (issue_use_imm_i),
    .issue_branch_i  (issue_branch_i),
    .issue_cond_i    (issue_cond_i),
    .issue_pc_i      (issue_pc_i),
    .of_valid_o      (of_valid),
    .of_op_o         (of_op),
    .of_rd_o         (of_rd),
    .of_rs1_o        (of_rs1),
    .of_rs2_o        (of_rs2),
    .of_imm_o        (of_imm),
    .of_use_imm_o    (of_use_imm),
    .of_branch_o     (of_branch),
    .of_cond_o       (of_cond),
    .of_pc_o         (of_pc)
  );

  execute_stage i_execute_stage (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .flush_i          (branch_taken_o),
    .of_valid_i       (of_valid),
    .of_op_i          (of_op),
    .of_rd_i          (of_rd),
    .of_rs1_i         (of_rs1),
    .of_rs2_i         (of_rs2),
    .of_imm_i         (of_imm),
    .of_use_imm_i     (of_use_imm),
    .of_branch_i      (of_branch),
    .of_cond_i        (of_cond),
    .of_pc_i          (of_pc),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .wb_rd_i          (wb_rd_o),
    .wb_data_i        (wb_data_o),
    .wb_write_i       (wb_valid_o),
    .ex_valid_o       (ex_valid),
    .ex_rd_o          (ex_rd),
    .ex_result_o      (ex_result),
    .ex_branch_o      (ex_branch),
    .ex_cond_o        (ex_cond),
    .ex_equal_o       (ex_equal),
    .ex_less_o        (ex_less),
    .ex_less_signed_o (ex_less_signed),
    .ex_target_o      (ex_target)
  );

  writeback_stage i_writeback_stage (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .ex_valid_i       (ex_valid),
    .ex_rd_i          (ex_rd),
    .ex_result_i      (ex_result),
    .ex_branch_i      (ex_branch),
    .ex_cond_i        (ex_cond),
    .ex_equal_i       (ex_equal),
    .ex_less_i        (ex_less),
    .ex_less_signed_i (ex_less_signed),
    .ex_target_i      (ex_target),
    .wb_valid_o       (wb_valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .branch_taken_o   (branch_taken_o),
    .branch_target_o  (branch_target_o)
  );

endmodule

`default_nettype wire

// File: src/writeback_stage.sv
`timescale 1ns/100ps
`default_nettype none

module writeback_stage import rv32_exec_pkg::*; (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic ex_valid_i,
  input  reg_addr_t ex_rd_i,
  input  word_t     ex_result_i,
  input  wire logic ex_branch_i,
  input  br_cond_e  ex_cond_i,
  input  wire logic ex_equal_i,
  input  wire logic ex_less_i,
  input  wire logic ex_less_signed_i,
  input  word_t     ex_target_i,
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o,
  output logic      branch_taken_o,
  output word_t     branch_target_o
);

  logic cond_met;

  always_comb begin
    case (ex_cond_i)
      BR_EQ:   cond_met = ex_equal_i;
      BR_NE:   cond_met = !ex_equal_i;
      BR_LT:   cond_met = ex_less_signed_i;
      BR_GE:   cond_met = !ex_less_signed_i;
      BR_LTU:  cond_met = ex_less_i;
      BR_GEU:  cond_met = !ex_less_i;
      default: cond_met = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || branch_taken_o) begin
      // a taken branch also drops whatever follows it
      wb_valid_o      <= 1'b0;
      wb_rd_o         <= '0;
      wb_data_o       <= '0;
      branch_taken_o  <= 1'b0;
      branch_target_o <= '0;
    end else begin
      wb_valid_o      <= ex_valid_i && !ex_branch_i && (ex_rd_i != '0);
      wb_rd_o         <= ex_rd_i;
      wb_data_o       <= ex_result_i;
      branch_taken_o  <= ex_valid_i && ex_branch_i && cond_met;
      branch_target_o <= ex_target_i;
    end
  end

  // stage 4 is cleared by the same taken branch
  a_branch_clears_ex: assert property (@(posedge clk_i) disable iff (reset_i)
    branch_taken_o |=> !ex_valid_i);

endmodule

`default_nettype wire

// File: src/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage import rv32_exec_pkg::*; (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic flush_i,
  input  wire logic of_valid_i,
  input  alu_op_e   of_op_i,
  input  reg_addr_t of_rd_i,
  input  reg_addr_t of_rs1_i,
  input  reg_addr_t of_rs2_i,
  input  word_t     of_imm_i,
  input  wire logic of_use_imm_i,
  input  wire logic of_branch_i,
  input  br_cond_e  of_cond_i,
  input  word_t     of_pc_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  reg_addr_t wb_rd_i,
  input  word_t     wb_data_i,
  input  wire logic wb_write_i,
  output logic      ex_valid_o,
  output reg_addr_t ex_rd_o,
  output word_t     ex_result_o,
  output logic      ex_branch_o,
  output br_cond_e  ex_cond_o,
  output logic      ex_equal_o,
  output logic      ex_less_o,
  output logic      ex_less_signed_o,
  output word_t     ex_target_o
);

  reg_addr_t rd_q;
  word_t     op1;
  word_t     op2_fwd;
  word_t     op2;
  word_t     alu_result;

  // invalid or branch slots never forward
  assign ex_rd_o = ex_valid_o ? rd_q : '0;

  // stage 4 wins over writeback, which wins over the register read
  function automatic word_t fwd(input reg_addr_t addr, input word_t rf_data);
    if ((addr != '0) && (addr == ex_rd_o)) begin
      return ex_result_o;
    end
    if (wb_write_i && (addr != '0) && (addr == wb_rd_i)) begin
      return wb_data_i;
    end
    return rf_data;
  endfunction

  always_comb begin
    op1     = fwd(of_rs1_i, rs1_data_i);
    op2_fwd = fwd(of_rs2_i, rs2_data_i);
    op2     = of_use_imm_i ? of_imm_i : op2_fwd;
  end

  alu i_alu (
    .op_i     (of_op_i),
    .a_i      (op1),
    .b_i      (op2),
    .result_o (alu_result)
  );

  ////////////////////////////////////////////////////////////
  // stage 4 registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_o       <= 1'b0;
      rd_q             <= '0;
      ex_result_o      <= '0;
      ex_branch_o      <= 1'b0;
      ex_cond_o        <= BR_EQ;
      ex_equal_o       <= 1'b0;
      ex_less_o        <= 1'b0;
      ex_less_signed_o <= 1'b0;
      ex_target_o      <= '0;
    end else if (flush_i) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= of_valid_i;
      if (of_valid_i) begin
        rd_q             <= of_branch_i ? '0 : of_rd_i;
        ex_result_o      <= alu_result;
        ex_branch_o      <= of_branch_i;
        ex_cond_o        <= of_cond_i;
        // compare always uses both register operands
        ex_equal_o       <= (op1 == op2_fwd);
        ex_less_o        <= (op1 < op2_fwd);
        ex_less_signed_o <= ($signed(op1) < $signed(op2_fwd));
        ex_target_o      <= of_pc_i + of_imm_i;
      end
    end
  end

  // operand fetch is cleared by the same flush
  a_flush_kills_ex: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> (!ex_valid_o && !of_valid_i));

endmodule

`default_nettype wire

// File: src/operand_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module operand_fetch import rv32_exec_pkg::*; (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic flush_i,
  input  wire logic issue_valid_i,
  input  alu_op_e   issue_op_i,
  input  reg_addr_t issue_rd_i,
  input  reg_addr_t issue_rs1_i,
  input  reg_addr_t issue_rs2_i,
  input  word_t     issue_imm_i,
  input  wire logic issue_use_imm_i,
  input  wire logic issue_branch_i,
  input  br_cond_e  issue_cond_i,
  input  word_t     issue_pc_i,
  output logic      of_valid_o,
  output alu_op_e   of_op_o,
  output reg_addr_t of_rd_o,
  output reg_addr_t of_rs1_o,
  output reg_addr_t of_rs2_o,
  output word_t     of_imm_o,
  output logic      of_use_imm_o,
  output logic      of_branch_o,
  output br_cond_e  of_cond_o,
  output word_t     of_pc_o
);

  ////////////////////////////////////////////////////////////
  // issue capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      of_valid_o   <= 1'b0;
      of_op_o      <= ALU_ADD;
      of_rd_o      <= '0;
      of_rs1_o     <= '0;
      of_rs2_o     <= '0;
      of_imm_o     <= '0;
      of_use_imm_o <= 1'b0;
      of_branch_o  <= 1'b0;
      of_cond_o    <= BR_EQ;
      of_pc_o      <= '0;
    end else if (flush_i) begin
      // issue inputs are dropped while a taken branch clears
      of_valid_o <= 1'b0;
    end else begin
      of_valid_o <= issue_valid_i;
      if (issue_valid_i) begin
        of_op_o      <= issue_op_i;
        of_rd_o      <= issue_rd_i;
        // source indices travel on for forwarding
        of_rs1_o     <= issue_rs1_i;
        of_rs2_o     <= issue_rs2_i;
        of_imm_o     <= issue_imm_i;
        of_use_imm_o <= issue_use_imm_i;
        of_branch_o  <= issue_branch_i;
        of_cond_o    <= issue_cond_i;
        of_pc_o      <= issue_pc_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv32_exec_macros.svh"

module reg_file import rv32_exec_pkg::*; (
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  input  wire logic wr_en_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o
);

  word_t regs_q [`REG_COUNT];

  // x0 is hardwired, a same-edge write is passed through
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en_i && (wr_addr_i == addr)) begin
      return wr_data_i;
    end
    return regs_q[addr];
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
      rs1_data_o <= '0;
      rs2_data_o <= '0;
    end else begin
      if (wr_en_i && (wr_addr_i != '0)) begin
        regs_q[wr_addr_i] <= wr_data_i;
      end
      rs1_data_o <= read_port(rs1_addr_i);
      rs2_data_o <= read_port(rs2_addr_i);
    end
  end

  // writeback only strobes for a nonzero rd
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_en_i |-> (wr_addr_i != '0));

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import rv32_exec_pkg::*; (
  input  alu_op_e op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output word_t   result_o
);

  logic [4:0] shamt;

  // only the low five bits shift on rv32
  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
      end
      ALU_SLL: begin
        result_o = a_i << shamt;
      end
      ALU_SLT: begin
        result_o = word_t'($signed(a_i) < $signed(b_i));
      end
      ALU_SLTU: begin
        result_o = word_t'(a_i < b_i);
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALU_SRL: begin
        result_o = a_i >> shamt;
      end
      ALU_SRA: begin
        result_o = word_t'($signed(a_i) >>> shamt);
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/rv32_exec_pkg.sv
`default_nettype none

`include "rv32_exec_macros.svh"

package rv32_exec_pkg;

  // data word and register index
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

  // rv32i alu operations, numbered in order
  typedef enum logic [`ALU_OP_W-1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // branch conditions, same as the funct3 field
  typedef enum logic [`BR_COND_W-1:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

endpackage

`default_nettype wire

// File: src/rv32_exec_macros.svh
`ifndef RV32_EXEC_MACROS_SVH
`define RV32_EXEC_MACROS_SVH

// data path word width
`define XLEN 32

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// operation encodings
`define ALU_OP_W 4
`define BR_COND_W 3

`endif
